/* design/core_pkg.sv */
package core_pkg;

   localparam int xlen     = 32;
   localparam int num_regs = 8;

   typedef logic [xlen-1:0] word_t;     // Data word or byte address
   typedef logic [2:0]      reg_idx_t;  // eax .. edi
   typedef logic [15:0]     imm_t;

   localparam word_t reset_pc = '0;

   // Instruction word: op 31..28, dest 26..24, src 22..20, imm 15..0
   typedef enum logic [3:0] {
      op_mov_imm = 4'd0,
      op_add     = 4'd1,
      op_sub     = 4'd2,
      op_and     = 4'd3,
      op_or      = 4'd4,
      op_xor     = 4'd5,
      op_add_imm = 4'd6,
      op_load    = 4'd7,
      op_store   = 4'd8,
      op_jmp     = 4'd9,
      op_halt    = 4'd10
   } opcode_t;

   // Fetch to register access
   typedef struct packed {
      word_t instr;
      word_t pc;
   } fetch_pkt_t;

   // Register access to execute
   typedef struct packed {
      opcode_t  opcode;
      reg_idx_t dest;
      word_t    dest_val;
      word_t    src_val;
      word_t    imm;       // Already sign-extended
      word_t    pc;
   } exec_pkt_t;

endpackage

/* design/bus_pkg.sv */
package bus_pkg;

   localparam int strb_w = core_pkg::xlen / 8;
   localparam logic [strb_w-1:0] full_strb = '1;  // Whole-word writes only

   // Internal requester port
   typedef struct packed {
      logic            valid;
      logic            write;
      core_pkg::word_t addr;
      core_pkg::word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic            ready;   // Grant
      logic            rvalid;  // One pulse per granted request
      core_pkg::word_t rdata;
   } mem_rsp_t;

   // AXI4-Lite master outputs
   typedef struct packed {
      logic              awvalid;
      core_pkg::word_t   awaddr;
      logic              wvalid;
      core_pkg::word_t   wdata;
      logic [strb_w-1:0] wstrb;
      logic              bready;
      logic              arvalid;
      core_pkg::word_t   araddr;
      logic              rready;
   } axi_m2s_t;

   typedef struct packed {
      logic            awready;
      logic            wready;
      logic            bvalid;
      logic [1:0]      bresp;
      logic            arready;
      logic            rvalid;
      core_pkg::word_t rdata;
      logic [1:0]      rresp;
   } axi_s2m_t;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 redirect,
   input  core_pkg::word_t      redirect_pc,
   output bus_pkg::mem_req_t    mem_req,
   input  bus_pkg::mem_rsp_t    mem_rsp,
   output logic                 out_valid,
   input  logic                 out_ready,
   output core_pkg::fetch_pkt_t out_pkt,
   output logic                 halted
);
   import core_pkg::*;
   import bus_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_request,
      s_wait,
      s_hold
   } state_t;

   state_t     state;
   word_t      pc_q;        // Next word to fetch
   word_t      req_addr_q;
   word_t      next_pc;
   logic       drop_q;      // Outstanding response is stale
   logic       halted_q;
   logic       rsp_halt;
   fetch_pkt_t pkt_q;

   assign next_pc  = redirect ? redirect_pc : pc_q;
   assign rsp_halt = (opcode_t'(mem_rsp.rdata[31:28]) == op_halt);

   assign mem_req.valid = (state == s_request);
   assign mem_req.write = 1'b0;
   assign mem_req.addr  = req_addr_q;
   assign mem_req.wdata = '0;

   assign out_valid = (state == s_hold);
   assign out_pkt   = pkt_q;
   assign halted    = halted_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= s_idle;
         pc_q       <= reset_pc;
         req_addr_q <= reset_pc;
         drop_q     <= 1'b0;
         halted_q   <= 1'b0;
      end else begin
         if (redirect)
            pc_q <= redirect_pc;
         case (state)
            s_idle: begin
               // A jmp older than the halt word still restarts fetch
               if (!halted_q || redirect) begin
                  halted_q   <= 1'b0;
                  req_addr_q <= next_pc;
                  pc_q       <= next_pc + 32'd4;
                  state      <= s_request;
               end
            end
            s_request: begin
               if (redirect)
                  drop_q <= 1'b1;
               if (mem_rsp.ready)
                  state <= s_wait;
            end
            s_wait: begin
               if (mem_rsp.rvalid) begin
                  if (drop_q || redirect) begin
                     drop_q     <= 1'b0;
                     req_addr_q <= next_pc;
                     pc_q       <= next_pc + 32'd4;
                     state      <= s_request;
                  end else if (rsp_halt) begin
                     halted_q <= 1'b1;
                     state    <= s_idle;
                  end else begin
                     state <= s_hold;
                  end
               end else if (redirect) begin
                  drop_q <= 1'b1;
               end
            end
            s_hold: begin
               if (redirect || out_ready) begin
                  req_addr_q <= next_pc;
                  pc_q       <= next_pc + 32'd4;
                  state      <= s_request;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == s_wait && mem_rsp.rvalid) begin
         pkt_q.instr <= mem_rsp.rdata;
         pkt_q.pc    <= req_addr_q;
      end
   end

endmodule

/* design/register_access.sv */
`timescale 1ns/10ps

module register_access (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  core_pkg::fetch_pkt_t in_pkt,
   input  logic                 flush,
   output logic                 out_valid,
   input  logic                 out_ready,
   output core_pkg::exec_pkt_t  out_pkt,
   input  logic                 wb_en,
   input  core_pkg::reg_idx_t   wb_idx,
   input  core_pkg::word_t      wb_data,
   input  logic                 busy_dest_valid,
   input  core_pkg::reg_idx_t   busy_dest
);
   import core_pkg::*;

   word_t     regs [num_regs];
   exec_pkt_t pkt_q;
   logic      valid_q;

   opcode_t  in_op;
   reg_idx_t in_dest;
   reg_idx_t in_src;
   imm_t     in_imm;
   word_t    dest_val;
   word_t    src_val;
   logic     reads_dest;
   logic     reads_src;
   logic     hazard;

   assign in_op   = opcode_t'(in_pkt.instr[31:28]);
   assign in_dest = in_pkt.instr[26:24];
   assign in_src  = in_pkt.instr[22:20];
   assign in_imm  = in_pkt.instr[15:0];

   always_comb begin
      reads_dest = 1'b0;
      reads_src  = 1'b0;
      case (in_op)
         op_add, op_sub, op_and, op_or, op_xor, op_store: begin
            reads_dest = 1'b1;
            reads_src  = 1'b1;
         end
         op_add_imm: reads_dest = 1'b1;
         op_load:    reads_src  = 1'b1;
         default:    ;
      endcase
   end

   // Write-back in the same cycle wins over the array
   assign dest_val = (wb_en && wb_idx == in_dest) ? wb_data : regs[in_dest];
   assign src_val  = (wb_en && wb_idx == in_src) ? wb_data : regs[in_src];

   assign hazard = busy_dest_valid &&
                   ((reads_dest && busy_dest == in_dest) || (reads_src && busy_dest == in_src));

   assign in_ready  = !valid_q && !hazard;
   assign out_valid = valid_q;
   assign out_pkt   = pkt_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++)
            regs[i] <= '0;
      end else if (wb_en) begin
         regs[wb_idx] <= wb_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         valid_q <= 1'b0;
      else if (flush)
         valid_q <= 1'b0;   // Wrong path after jmp
      else if (in_valid && in_ready)
         valid_q <= 1'b1;
      else if (out_ready)
         valid_q <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         pkt_q.opcode   <= in_op;
         pkt_q.dest     <= in_dest;
         pkt_q.dest_val <= dest_val;
         pkt_q.src_val  <= src_val;
         pkt_q.imm      <= {{(xlen-16){in_imm[15]}}, in_imm};
         pkt_q.pc       <= in_pkt.pc;
      end
   end

endmodule

/* design/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   output logic                in_ready,
   input  core_pkg::exec_pkt_t in_pkt,
   output bus_pkg::mem_req_t   mem_req,
   input  bus_pkg::mem_rsp_t   mem_rsp,
   output logic                wb_en,
   output core_pkg::reg_idx_t  wb_idx,
   output core_pkg::word_t     wb_data,
   output logic                busy_dest_valid,
   output core_pkg::reg_idx_t  busy_dest,
   output logic                redirect,
   output core_pkg::word_t     redirect_pc
);
   import core_pkg::*;
   import bus_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_memory,
      s_done
   } state_t;

   state_t    state;
   exec_pkt_t pkt_q;
   logic      req_sent_q;   // Grant seen, waiting for the response
   logic      take;
   logic      in_is_mem;
   logic      is_load;
   logic      is_jmp;
   logic      writes_reg;
   word_t     alu_res;
   word_t     mem_addr;

   assign is_load    = (pkt_q.opcode == op_load);
   assign is_jmp     = (pkt_q.opcode == op_jmp);
   assign writes_reg = pkt_q.opcode inside {op_mov_imm, op_add, op_sub, op_and, op_or,
                                            op_xor, op_add_imm, op_load};
   assign in_is_mem  = in_pkt.opcode inside {op_load, op_store};

   always_comb begin
      case (pkt_q.opcode)
         op_mov_imm: alu_res = pkt_q.imm;
         op_add:     alu_res = pkt_q.dest_val + pkt_q.src_val;
         op_sub:     alu_res = pkt_q.dest_val - pkt_q.src_val;
         op_and:     alu_res = pkt_q.dest_val & pkt_q.src_val;
         op_or:      alu_res = pkt_q.dest_val | pkt_q.src_val;
         op_xor:     alu_res = pkt_q.dest_val ^ pkt_q.src_val;
         op_add_imm: alu_res = pkt_q.dest_val + pkt_q.imm;
         default:    alu_res = pkt_q.dest_val;
      endcase
   end

   assign mem_addr = pkt_q.src_val + pkt_q.imm;

   // No intake behind a jmp, the next packet is wrong path
   assign in_ready = (state == s_idle) || (state == s_done && !is_jmp);
   assign take     = in_valid && in_ready;

   assign mem_req.valid = (state == s_memory) && !req_sent_q;
   assign mem_req.write = !is_load;
   assign mem_req.addr  = mem_addr;
   assign mem_req.wdata = pkt_q.dest_val;   // Store data

   assign wb_en   = (state == s_done && writes_reg) ||
                    (state == s_memory && mem_rsp.rvalid && is_load);
   assign wb_idx  = pkt_q.dest;
   assign wb_data = (state == s_memory) ? mem_rsp.rdata : alu_res;

   assign busy_dest_valid = (state != s_idle) && writes_reg && !wb_en;
   assign busy_dest       = pkt_q.dest;

   assign redirect    = (state == s_done) && is_jmp;
   assign redirect_pc = {pkt_q.imm[xlen-3:0], 2'b00};   // Word index to byte address

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= s_idle;
         req_sent_q <= 1'b0;
      end else begin
         case (state)
            s_memory: begin
               if (mem_rsp.ready)
                  req_sent_q <= 1'b1;
               if (mem_rsp.rvalid) begin
                  req_sent_q <= 1'b0;
                  state      <= s_idle;
               end
            end
            default: begin
               if (take)
                  state <= in_is_mem ? s_memory : s_done;
               else
                  state <= s_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take)
         pkt_q <= in_pkt;
   end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
   input  logic              clk,
   input  logic              rst_n,
   input  bus_pkg::mem_req_t fetch_req,
   output bus_pkg::mem_rsp_t fetch_rsp,
   input  bus_pkg::mem_req_t data_req,
   output bus_pkg::mem_rsp_t data_rsp,
   output bus_pkg::axi_m2s_t axi_req,
   input  bus_pkg::axi_s2m_t axi_rsp
);
   import core_pkg::*;
   import bus_pkg::*;

   typedef enum logic [2:0] {
      s_idle,
      s_rd_addr,
      s_rd_data,
      s_wr_addr,
      s_wr_resp
   } state_t;

   state_t   state;
   logic     owner_data_q;   // Execute holds the bus
   logic     aw_done_q;
   logic     w_done_q;
   word_t    addr_q;
   word_t    wdata_q;
   logic     grant_data;
   logic     grant_fetch;
   logic     aw_hs;
   logic     w_hs;
   logic     done;
   mem_req_t sel_req;

   // Execute first, a stalled execute blocks everything behind it
   assign grant_data  = (state == s_idle) && data_req.valid;
   assign grant_fetch = (state == s_idle) && !data_req.valid && fetch_req.valid;
   assign sel_req     = grant_data ? data_req : fetch_req;

   assign axi_req.awvalid = (state == s_wr_addr) && !aw_done_q;
   assign axi_req.awaddr  = addr_q;
   assign axi_req.wvalid  = (state == s_wr_addr) && !w_done_q;
   assign axi_req.wdata   = wdata_q;
   assign axi_req.wstrb   = full_strb;
   assign axi_req.bready  = (state == s_wr_resp);
   assign axi_req.arvalid = (state == s_rd_addr);
   assign axi_req.araddr  = addr_q;
   assign axi_req.rready  = (state == s_rd_data);

   assign aw_hs = axi_req.awvalid && axi_rsp.awready;
   assign w_hs  = axi_req.wvalid && axi_rsp.wready;
   assign done  = (state == s_rd_data && axi_rsp.rvalid) ||
                  (state == s_wr_resp && axi_rsp.bvalid);

   assign fetch_rsp.ready  = grant_fetch;
   assign fetch_rsp.rvalid = done && !owner_data_q;
   assign fetch_rsp.rdata  = axi_rsp.rdata;
   assign data_rsp.ready   = grant_data;
   assign data_rsp.rvalid  = done && owner_data_q;
   assign data_rsp.rdata   = axi_rsp.rdata;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state        <= s_idle;
         owner_data_q <= 1'b0;
         aw_done_q    <= 1'b0;
         w_done_q     <= 1'b0;
      end else begin
         case (state)
            s_idle: begin
               if (grant_data || grant_fetch) begin
                  owner_data_q <= grant_data;
                  state        <= sel_req.write ? s_wr_addr : s_rd_addr;
               end
            end
            s_rd_addr: if (axi_rsp.arready) state <= s_rd_data;
            s_rd_data: if (axi_rsp.rvalid) state <= s_idle;
            s_wr_addr: begin
               // aw and w may be accepted in either order
               if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                  aw_done_q <= 1'b0;
                  w_done_q  <= 1'b0;
                  state     <= s_wr_resp;
               end else begin
                  if (aw_hs)
                     aw_done_q <= 1'b1;
                  if (w_hs)
                     w_done_q <= 1'b1;
               end
            end
            s_wr_resp: if (axi_rsp.bvalid) state <= s_idle;
            default:   state <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (grant_data || grant_fetch) begin
         addr_q  <= sel_req.addr;
         wdata_q <= sel_req.wdata;
      end
   end

endmodule

/* design/pipeline_top.sv */
`timescale 1ns/10ps

module pipeline_top (
   input  logic              clk,
   input  logic              rst_n,
   output bus_pkg::axi_m2s_t axi_req,
   input  bus_pkg::axi_s2m_t axi_rsp,
   output logic              halted
);
   import core_pkg::*;
   import bus_pkg::*;

   mem_req_t   fetch_req;
   mem_rsp_t   fetch_rsp;
   mem_req_t   data_req;
   mem_rsp_t   data_rsp;
   logic       f_valid;
   logic       f_ready;
   fetch_pkt_t f_pkt;
   logic       r_valid;
   logic       r_ready;
   exec_pkt_t  r_pkt;
   logic       wb_en;
   reg_idx_t   wb_idx;
   word_t      wb_data;
   logic       busy_dest_valid;
   reg_idx_t   busy_dest;
   logic       redirect;     // jmp completed in execute
   word_t      redirect_pc;

   fetch_unit fetch_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .mem_req     (fetch_req),
      .mem_rsp     (fetch_rsp),
      .out_valid   (f_valid),
      .out_ready   (f_ready),
      .out_pkt     (f_pkt),
      .halted      (halted)
   );

   register_access reg_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .in_valid        (f_valid),
      .in_ready        (f_ready),
      .in_pkt          (f_pkt),
      .flush           (redirect),
      .out_valid       (r_valid),
      .out_ready       (r_ready),
      .out_pkt         (r_pkt),
      .wb_en           (wb_en),
      .wb_idx          (wb_idx),
      .wb_data         (wb_data),
      .busy_dest_valid (busy_dest_valid),
      .busy_dest       (busy_dest)
   );

   execute_unit exec_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .in_valid        (r_valid),
      .in_ready        (r_ready),
      .in_pkt          (r_pkt),
      .mem_req         (data_req),
      .mem_rsp         (data_rsp),
      .wb_en           (wb_en),
      .wb_idx          (wb_idx),
      .wb_data         (wb_data),
      .busy_dest_valid (busy_dest_valid),
      .busy_dest       (busy_dest),
      .redirect        (redirect),
      .redirect_pc     (redirect_pc)
   );

   mem_arbiter arb_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .fetch_req (fetch_req),
      .fetch_rsp (fetch_rsp),
      .data_req  (data_req),
      .data_rsp  (data_rsp),
      .axi_req   (axi_req),
      .axi_rsp   (axi_rsp)
   );

endmodule

/* sim/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model #(
   parameter logic [31:0] seed = 32'hd5d7
) (
   input  logic              clk,
   input  logic              rst_n,
   input  bus_pkg::axi_m2s_t axi_req,
   output bus_pkg::axi_s2m_t axi_rsp
);
   import core_pkg::*;
   import bus_pkg::*;

   localparam int depth = 256;

   word_t       mem [depth];
   logic [31:0] lfsr = seed;
   logic [1:0]  rd_wait;    // Cycles left before arready
   logic [1:0]  aw_wait;
   logic [1:0]  w_wait;
   logic        aw_got;
   logic        w_got;
   word_t       wr_addr;
   word_t       wr_data;

   // Fibonacci form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [1:0] draw_delay();
      logic [1:0] d;
      for (int i = 0; i < 2; i++) begin
         lfsr = lfsr_next(lfsr);
         d[i] = lfsr[0];
      end
      return d;
   endfunction

   task automatic backdoor_write(input int idx, input word_t data);
      mem[idx] = data;
   endtask

   initial axi_rsp = '0;

   always @(posedge clk) begin
      if (!rst_n) begin
         axi_rsp <= '0;
         aw_got  <= 1'b0;
         w_got   <= 1'b0;
         rd_wait <= draw_delay();
         aw_wait <= draw_delay();
         w_wait  <= draw_delay();
      end else begin
         if (axi_req.arvalid && axi_rsp.arready) begin
            axi_rsp.arready <= 1'b0;
            axi_rsp.rvalid  <= 1'b1;
            axi_rsp.rdata   <= mem[axi_req.araddr[9:2]];
            rd_wait         <= draw_delay();
         end else if (axi_req.arvalid && !axi_rsp.arready && !axi_rsp.rvalid) begin
            if (rd_wait == 2'd0)
               axi_rsp.arready <= 1'b1;
            else
               rd_wait <= rd_wait - 2'd1;
         end
         if (axi_rsp.rvalid && axi_req.rready)
            axi_rsp.rvalid <= 1'b0;

         if (axi_req.awvalid && axi_rsp.awready) begin
            axi_rsp.awready <= 1'b0;
            aw_got          <= 1'b1;
            wr_addr         <= axi_req.awaddr;
            aw_wait         <= draw_delay();
         end else if (axi_req.awvalid && !axi_rsp.awready && !aw_got) begin
            if (aw_wait == 2'd0)
               axi_rsp.awready <= 1'b1;
            else
               aw_wait <= aw_wait - 2'd1;
         end

         if (axi_req.wvalid && axi_rsp.wready) begin
            axi_rsp.wready <= 1'b0;
            w_got          <= 1'b1;
            wr_data        <= axi_req.wdata;
            w_wait         <= draw_delay();
         end else if (axi_req.wvalid && !axi_rsp.wready && !w_got) begin
            if (w_wait == 2'd0)
               axi_rsp.wready <= 1'b1;
            else
               w_wait <= w_wait - 2'd1;
         end

         // Both halves in, commit and answer
         if (aw_got && w_got && !axi_rsp.bvalid) begin
            mem[wr_addr[9:2]] <= wr_data;
            axi_rsp.bvalid    <= 1'b1;
            aw_got            <= 1'b0;
            w_got             <= 1'b0;
         end
         if (axi_rsp.bvalid && axi_req.bready)
            axi_rsp.bvalid <= 1'b0;
      end
   end

endmodule

/* sim/tb_pipeline.sv */
`timescale 1ns/10ps

module tb_pipeline;
   import core_pkg::*;
   import bus_pkg::*;

   localparam int mem_words        = 256;
   localparam int cycles_per_instr = 400;

   localparam reg_idx_t eax = 3'd0;
   localparam reg_idx_t ecx = 3'd1;
   localparam reg_idx_t edx = 3'd2;
   localparam reg_idx_t ebx = 3'd3;
   localparam reg_idx_t esi = 3'd6;
   localparam reg_idx_t edi = 3'd7;

   logic     clk;
   logic     rst_n;
   logic     halted;
   axi_m2s_t axi_req;
   axi_s2m_t axi_rsp;

   word_t    ref_mem [mem_words];
   word_t    ref_regs [num_regs];
   logic     ar_allowed [mem_words];   // Words the bus may legally read
   word_t    exp_addr [$];
   word_t    exp_data [$];
   word_t    program_img [$];
   int       value_errors    = 0;
   int       protocol_errors = 0;
   int       aw_count        = 0;
   int       w_count         = 0;
   int       open_txn        = 0;
   int       watchdog_cycles = 0;
   logic     rst_q           = 1'bx;
   logic     halted_q        = 1'b0;
   axi_m2s_t req_q;
   axi_s2m_t rsp_q;

   pipeline_top pipeline_top_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .axi_req (axi_req),
      .axi_rsp (axi_rsp),
      .halted  (halted)
   );

   axi_mem_model mem_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .axi_req (axi_req),
      .axi_rsp (axi_rsp)
   );

   function automatic word_t encode(logic [3:0] op, reg_idx_t dest, reg_idx_t src, imm_t imm);
      return {op, 1'b0, dest, 1'b0, src, 4'h0, imm};
   endfunction

   // Opcode 0xb makes a stray fetch a no-op
   function automatic word_t fill_word(int idx);
      return 32'hb000_0000 | (idx * 32'h0001_0101);
   endfunction

   task automatic show_mismatch(input string name, input word_t expected, input word_t actual);
      value_errors++;
      $display("** Error: %s expected %h, got %h", name, expected, actual);
   endtask

   task automatic report_rule(input string what);
      protocol_errors++;
      $display("Bus check failed at %0t: %s", $time, what);
   endtask

   task automatic finish_run(input logic timed_out);
      $display("Errors: %0d value, %0d protocol, %0d timeout",
               value_errors, protocol_errors, timed_out);
      if (timed_out || value_errors + protocol_errors != 0)
         $display("Testbench failed");
      else
         $display("Testbench passed");
      $finish;
   endtask

   task automatic build_program();
      program_img.push_back(encode(op_mov_imm, eax, eax, 16'h1234));
      program_img.push_back(encode(op_mov_imm, ecx, eax, 16'hfffd));
      program_img.push_back(encode(op_add,     eax, ecx, 16'h0000));
      program_img.push_back(encode(op_mov_imm, esi, eax, 16'h0200));  // Data base
      program_img.push_back(encode(op_store,   eax, esi, 16'h0000));
      program_img.push_back(encode(op_mov_imm, edx, eax, 16'h0ff0));
      program_img.push_back(encode(op_sub,     edx, eax, 16'h0000));
      program_img.push_back(encode(op_store,   edx, esi, 16'h0004));
      program_img.push_back(encode(op_mov_imm, ebx, eax, 16'h7777));
      program_img.push_back(encode(op_and,     ebx, edx, 16'h0000));
      program_img.push_back(encode(op_or,      ebx, ecx, 16'h0000));
      program_img.push_back(encode(op_xor,     ebx, eax, 16'h0000));
      program_img.push_back(encode(op_add_imm, ebx, eax, 16'h8001));
      program_img.push_back(encode(op_store,   ebx, esi, 16'h0008));
      program_img.push_back(encode(op_load,    edi, esi, 16'h0004));
      program_img.push_back(encode(op_add,     edi, eax, 16'h0000));  // Uses the load result
      program_img.push_back(encode(op_store,   edi, esi, 16'h000c));
      program_img.push_back(encode(op_jmp,     eax, eax, 16'd20));
      program_img.push_back(encode(op_store,   eax, esi, 16'h0010));  // Skipped
      program_img.push_back(encode(op_mov_imm, eax, eax, 16'h0000));
      program_img.push_back(encode(op_add_imm, eax, eax, 16'h0001));  // Jump target
      program_img.push_back(encode(op_store,   eax, esi, 16'h0014));
      program_img.push_back(encode(4'hc,       ecx, ecx, 16'h0000));
      program_img.push_back(encode(op_mov_imm, ecx, eax, 16'h0005));
      program_img.push_back(encode(op_halt,    eax, eax, 16'h0000));
   endtask

   // Executes the image one instruction at a time
   task automatic run_reference();
      word_t      pc;
      word_t      instr;
      word_t      imm;
      word_t      addr;
      logic [3:0] op;
      reg_idx_t   d;
      reg_idx_t   s;
      int         steps;
      logic       stop;
      pc    = reset_pc;
      steps = 0;
      stop  = 1'b0;
      foreach (ref_regs[i])
         ref_regs[i] = '0;
      while (!stop && steps < 1000) begin
         ar_allowed[pc[9:2]] = 1'b1;
         instr = ref_mem[pc[9:2]];
         op    = instr[31:28];
         d     = instr[26:24];
         s     = instr[22:20];
         imm   = {{16{instr[15]}}, instr[15:0]};
         addr  = ref_regs[s] + imm;
         pc    = pc + 32'd4;
         steps++;
         case (op)
            op_mov_imm: ref_regs[d] = imm;
            op_add:     ref_regs[d] = ref_regs[d] + ref_regs[s];
            op_sub:     ref_regs[d] = ref_regs[d] - ref_regs[s];
            op_and:     ref_regs[d] = ref_regs[d] & ref_regs[s];
            op_or:      ref_regs[d] = ref_regs[d] | ref_regs[s];
            op_xor:     ref_regs[d] = ref_regs[d] ^ ref_regs[s];
            op_add_imm: ref_regs[d] = ref_regs[d] + imm;
            op_load: begin
               ar_allowed[addr[9:2]] = 1'b1;
               ref_regs[d] = ref_mem[addr[9:2]];
            end
            op_store: begin
               ref_mem[addr[9:2]] = ref_regs[d];
               exp_addr.push_back(addr);
               exp_data.push_back(ref_regs[d]);
            end
            op_jmp: begin
               ar_allowed[pc[9:2]] = 1'b1;          // Two words may be fetched past a jmp
               ar_allowed[pc[9:2] + 8'd1] = 1'b1;
               pc = imm * 32'd4;
            end
            op_halt: stop = 1'b1;
            default: ;
         endcase
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      foreach (ar_allowed[i])
         ar_allowed[i] = 1'b0;
      build_program();
      for (int i = 0; i < mem_words; i++) begin
         ref_mem[i] = (i < program_img.size()) ? program_img[i] : fill_word(i);
         mem_inst.backdoor_write(i, ref_mem[i]);
      end
      run_reference();
      watchdog_cycles = cycles_per_instr * program_img.size();
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      wait (halted === 1'b1);
      repeat (50) @(posedge clk);   // Room for any late bus request to show
      assert (aw_count == exp_addr.size())
         else show_mismatch("write count", exp_addr.size(), aw_count);
      finish_run(1'b0);
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: halted did not rise within %0d cycles", watchdog_cycles);
      finish_run(1'b1);
   end

   always @(posedge clk) begin
      if (rst_q === 1'b0)
         assert (!axi_req.awvalid && !axi_req.wvalid && !axi_req.arvalid && !halted)
            else report_rule("valid or halted high during reset");
      if (rst_n === 1'b1 && rst_q === 1'b1) begin
         if (req_q.awvalid && !rsp_q.awready)
            assert (axi_req.awvalid && axi_req.awaddr == req_q.awaddr)
               else report_rule("awvalid or awaddr changed before awready");
         if (req_q.wvalid && !rsp_q.wready)
            assert (axi_req.wvalid && axi_req.wdata == req_q.wdata)
               else report_rule("wvalid or wdata changed before wready");
         if (req_q.arvalid && !rsp_q.arready)
            assert (axi_req.arvalid && axi_req.araddr == req_q.araddr)
               else report_rule("arvalid or araddr changed before arready");
         assert ((axi_req.awvalid && !req_q.awvalid) == (axi_req.wvalid && !req_q.wvalid))
            else report_rule("awvalid and wvalid did not rise together");
         assert (!axi_rsp.rvalid || axi_req.rready)
            else report_rule("rready low while a read response was waiting");
         assert (!axi_rsp.bvalid || axi_req.bready)
            else report_rule("bready low while a write response was waiting");
         assert (!halted || (!axi_req.arvalid && !axi_req.awvalid))
            else report_rule("bus request while halted");
         assert (!halted_q || halted)
            else report_rule("halted fell before reset");

         if ((axi_rsp.rvalid && axi_req.rready) || (axi_rsp.bvalid && axi_req.bready))
            open_txn--;
         if (axi_req.arvalid && axi_rsp.arready) begin
            assert (open_txn == 0) else report_rule("read started with a transaction open");
            open_txn++;
            assert (ar_allowed[axi_req.araddr[9:2]] && axi_req.araddr < 4 * mem_words)
               else begin
                  value_errors++;
                  $display("** Error: araddr got %h, a word the program never reads",
                           axi_req.araddr);
               end
         end
         if (axi_req.awvalid && axi_rsp.awready) begin
            assert (open_txn == 0) else report_rule("write started with a transaction open");
            open_txn++;
            if (aw_count < exp_addr.size()) begin
               assert (axi_req.awaddr == exp_addr[aw_count])
                  else show_mismatch("awaddr", exp_addr[aw_count], axi_req.awaddr);
            end else begin
               report_rule("more writes than the program stores");
            end
            aw_count++;
         end
         if (axi_req.wvalid && axi_rsp.wready) begin
            assert (axi_req.wstrb == 4'hf)
               else show_mismatch("wstrb", 32'hf, axi_req.wstrb);
            if (w_count < exp_data.size())
               assert (axi_req.wdata == exp_data[w_count])
                  else show_mismatch("wdata", exp_data[w_count], axi_req.wdata);
            w_count++;
         end
      end
      rst_q    = rst_n;
      halted_q = (rst_n === 1'b1) ? halted : 1'b0;
      req_q    = axi_req;
      rsp_q    = axi_rsp;
   end

endmodule

/* sources.f */
design/core_pkg.sv
design/bus_pkg.sv
design/fetch_unit.sv
design/register_access.sv
design/execute_unit.sv
design/mem_arbiter.sv
design/pipeline_top.sv
sim/axi_mem_model.sv
sim/tb_pipeline.sv

/* Bender.yml */
package:
  name: pipeline_axi

sources:
  - design/core_pkg.sv
  - design/bus_pkg.sv
  - design/fetch_unit.sv
  - design/register_access.sv
  - design/execute_unit.sv
  - design/mem_arbiter.sv
  - design/pipeline_top.sv
  - target: simulation
    files:
      - sim/axi_mem_model.sv
      - sim/tb_pipeline.sv
